/* noc_block_macros.svh */
`ifndef NOC_BLOCK_MACROS_SVH
`define NOC_BLOCK_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////////////////////////

// One packet line on the network side
`define NOC_LINE_W 64

// One complex sample, I and Q packed
`define NOC_SAMPLE_W 32

//////////////////////////////////////////////////////////////////////
// Filter geometry
//////////////////////////////////////////////////////////////////////

`define FIR_NUM_TAPS 8

// Q1.15 coefficients
`define FIR_COEF_W 16

//////////////////////////////////////////////////////////////////////
// Settings register map
//////////////////////////////////////////////////////////////////////

// First settings address owned by the filter
`define SR_FIR_BASE 8

// Offsets from the base
`define SR_FIR_COEF 0
`define SR_FIR_CLEAR 1

`endif

/* noc_chdr_pkg.sv */
`include "noc_block_macros.svh"

package noc_chdr_pkg;

  //////////////////////////////////////////////////////////////////////
  // Packet header
  //////////////////////////////////////////////////////////////////////

  // Single type bit in the top of the header
  typedef enum logic {
    PKT_DATA = 1'b0,
    PKT_CMD  = 1'b1
  } t_pkt_type;

  // First line of every packet
  typedef struct packed {
    t_pkt_type   pkt_type;  // 63
    logic [14:0] rsvd_hi;   // 62:48
    logic [15:0] sid;       // 47:32
    logic [15:0] rsvd_lo;   // 31:16
    logic [15:0] len;       // 15:0, payload lines
  } t_chdr_hdr;

  // Settings bus address
  typedef logic [7:0] t_set_addr;

  // Payload line of a command packet, one register write
  typedef struct packed {
    logic [`NOC_LINE_W-41:0] rsvd;  // 63:40
    t_set_addr               addr;  // 39:32
    logic [31:0]             data;  // 31:0
  } t_cmd_line;

endpackage

/* fir_dsp_pkg.sv */
`include "noc_block_macros.svh"

package fir_dsp_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sample side types
  //////////////////////////////////////////////////////////////////////

  // Complex sample, I in the upper half
  typedef struct packed {
    logic signed [`NOC_SAMPLE_W/2-1:0] i;
    logic signed [`NOC_SAMPLE_W/2-1:0] q;
  } t_sample;

  // Q1.15 tap weight
  typedef logic signed [`FIR_COEF_W-1:0] t_coef;

  // Room for 8 full scale products plus sign
  typedef logic signed [35:0] t_acc;

  // Sample with its packet delimiter
  typedef struct packed {
    t_sample data;
    logic    last;
  } t_sample_beat;

endpackage

/* axis_skid_buffer.sv */
`timescale 1ns/1ps

module axis_skid_buffer #(
  parameter type t_payload = logic
) (
  input  logic     bus_clk,
  input  logic     i_arst_n,
  // Upstream side
  input  t_payload i_data,
  input  logic     i_valid,
  output logic     o_ready,
  // Downstream side
  output t_payload o_data,
  output logic     o_valid,
  input  logic     i_ready
);

  // Overflow slot, filled when output stalls
  t_payload skid_data;
  logic     skid_valid;
  logic     out_free;
  logic     in_fire;

  // Ready comes straight from a flop
  assign o_ready  = ~skid_valid;
  assign in_fire  = i_valid & o_ready;
  assign out_free = ~o_valid | i_ready;

  // Occupancy
  always_ff @(posedge bus_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      // Drain skid first to keep order
      o_valid    <= skid_valid | in_fire;
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  // Payload moves with occupancy
  always_ff @(posedge bus_clk) begin
    if (out_free) begin
      o_data <= skid_valid ? skid_data : i_data;
    end else if (in_fire) begin
      skid_data <= i_data;
    end
  end

endmodule

/* noc_shell_lite.sv */
`timescale 1ns/1ps
`include "noc_block_macros.svh"

module noc_shell_lite (
  input  logic                    bus_clk,
  input  logic                    i_arst_n,
  // Packets in
  input  logic [`NOC_LINE_W-1:0]  i_tdata,
  input  logic                    i_tlast,
  input  logic                    i_tvalid,
  output logic                    o_tready,
  // Packets out
  output logic [`NOC_LINE_W-1:0]  o_tdata,
  output logic                    o_tlast,
  output logic                    o_tvalid,
  input  logic                    i_tready,
  // Settings strobe
  output logic                    o_set_stb,
  output noc_chdr_pkg::t_set_addr o_set_addr,
  output logic [31:0]             o_set_data,
  // Payload toward user logic
  output logic [`NOC_LINE_W-1:0]  o_sink_tdata,
  output logic                    o_sink_tlast,
  output logic                    o_sink_tvalid,
  input  logic                    i_sink_tready,
  // Payload back from user logic
  input  logic [`NOC_LINE_W-1:0]  i_src_tdata,
  input  logic                    i_src_tlast,
  input  logic                    i_src_tvalid,
  output logic                    o_src_tready
);

  typedef struct packed {
    logic [`NOC_LINE_W-1:0] line;
    logic                   last;
  } t_line_beat;

  typedef enum logic [1:0] {IN_HDR, IN_CMD, IN_DATA} t_in_state;
  typedef enum logic {OUT_HDR, OUT_DATA} t_out_state;

  t_line_beat              line_in;
  t_line_beat              line_buf;
  logic                    buf_valid;
  logic                    buf_ready;
  logic                    buf_fire;
  noc_chdr_pkg::t_chdr_hdr buf_hdr;
  noc_chdr_pkg::t_cmd_line buf_cmd;
  logic                    buf_is_cmd;
  t_in_state               in_state;
  t_out_state              out_state;
  // Two deep header queue
  noc_chdr_pkg::t_chdr_hdr hdr_q [2];
  logic                    hdr_wr_ptr;
  logic                    hdr_rd_ptr;
  logic [1:0]              hdr_cnt;
  logic                    hdr_push;
  logic                    hdr_pop;

  //////////////////////////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////////////////////////

  assign line_in = '{line: i_tdata, last: i_tlast};

  axis_skid_buffer #(.t_payload(t_line_beat)) u_in_skid (
    .bus_clk (bus_clk),
    .i_arst_n(i_arst_n),
    .i_data  (line_in),
    .i_valid (i_tvalid),
    .o_ready (o_tready),
    .o_data  (line_buf),
    .o_valid (buf_valid),
    .i_ready (buf_ready)
  );

  // Same line seen as header or as register write
  assign buf_hdr    = noc_chdr_pkg::t_chdr_hdr'(line_buf.line);
  assign buf_cmd    = noc_chdr_pkg::t_cmd_line'(line_buf.line);
  assign buf_is_cmd = (buf_hdr.pkt_type == noc_chdr_pkg::PKT_CMD);
  assign buf_fire   = buf_valid & buf_ready;

  assign o_sink_tdata  = line_buf.line;
  assign o_sink_tlast  = line_buf.last;
  assign o_sink_tvalid = buf_valid & (in_state == IN_DATA);

  // Data headers wait for a queue slot, commands never stall
  always_comb begin
    case (in_state)
      IN_HDR:  buf_ready = buf_is_cmd | (hdr_cnt != 2'd2);
      IN_DATA: buf_ready = i_sink_tready;
      default: buf_ready = 1'b1;
    endcase
  end

  always_ff @(posedge bus_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      in_state <= IN_HDR;
    end else if (buf_fire) begin
      if (in_state == IN_HDR) begin
        // Header-only packet stays here
        if (!line_buf.last) in_state <= buf_is_cmd ? IN_CMD : IN_DATA;
      end else if (line_buf.last) begin
        in_state <= IN_HDR;
      end
    end
  end

  // One pulse per command line
  always_ff @(posedge bus_clk or negedge i_arst_n) begin
    if (!i_arst_n) o_set_stb <= 1'b0;
    else           o_set_stb <= buf_fire & (in_state == IN_CMD);
  end

  always_ff @(posedge bus_clk) begin
    if (buf_fire && in_state == IN_CMD) begin
      o_set_addr <= buf_cmd.addr;
      o_set_data <= buf_cmd.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Header queue
  //////////////////////////////////////////////////////////////////////

  assign hdr_push = buf_fire & (in_state == IN_HDR) & ~buf_is_cmd & ~line_buf.last;
  assign hdr_pop  = o_tvalid & i_tready & (out_state == OUT_HDR);

  always_ff @(posedge bus_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      hdr_wr_ptr <= 1'b0;
      hdr_rd_ptr <= 1'b0;
      hdr_cnt    <= 2'd0;
    end else begin
      hdr_wr_ptr <= hdr_wr_ptr ^ hdr_push;
      hdr_rd_ptr <= hdr_rd_ptr ^ hdr_pop;
      hdr_cnt    <= hdr_cnt + {1'b0, hdr_push} - {1'b0, hdr_pop};
    end
  end

  always_ff @(posedge bus_clk) begin
    if (hdr_push) hdr_q[hdr_wr_ptr] <= buf_hdr;
  end

  //////////////////////////////////////////////////////////////////////
  // Output side
  //////////////////////////////////////////////////////////////////////

  // Header goes out unchanged, then payload until last
  always_comb begin
    if (out_state == OUT_HDR) begin
      o_tdata      = hdr_q[hdr_rd_ptr];
      o_tlast      = 1'b0;
      o_tvalid     = (hdr_cnt != 2'd0);
      o_src_tready = 1'b0;
    end else begin
      o_tdata      = i_src_tdata;
      o_tlast      = i_src_tlast;
      o_tvalid     = i_src_tvalid;
      o_src_tready = i_tready;
    end
  end

  always_ff @(posedge bus_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      out_state <= OUT_HDR;
    end else if (hdr_pop) begin
      out_state <= OUT_DATA;
    end else if (out_state == OUT_DATA && i_src_tvalid && i_tready && i_src_tlast) begin
      out_state <= OUT_HDR;
    end
  end

endmodule

/* simple_axi_wrapper.sv */
`timescale 1ns/1ps
`include "noc_block_macros.svh"

module simple_axi_wrapper (
  input  logic                    bus_clk,
  input  logic                    i_arst_n,
  // Settings strobe from shell
  input  logic                    i_set_stb,
  input  noc_chdr_pkg::t_set_addr i_set_addr,
  input  logic [31:0]             i_set_data,
  // Lines from shell
  input  logic [`NOC_LINE_W-1:0]  i_tdata,
  input  logic                    i_tlast,
  input  logic                    i_tvalid,
  output logic                    o_tready,
  // Lines back to shell
  output logic [`NOC_LINE_W-1:0]  o_tdata,
  output logic                    o_tlast,
  output logic                    o_tvalid,
  input  logic                    i_tready,
  // Samples to filter
  output fir_dsp_pkg::t_sample    o_pre_tdata,
  output logic                    o_pre_tlast,
  output logic                    o_pre_tvalid,
  input  logic                    i_pre_tready,
  // Samples from filter
  input  fir_dsp_pkg::t_sample    i_post_tdata,
  input  logic                    i_post_tlast,
  input  logic                    i_post_tvalid,
  output logic                    o_post_tready,
  // Config stream
  output fir_dsp_pkg::t_coef      o_cfg_coef,
  output logic                    o_cfg_clear,
  output logic                    o_cfg_valid
);

  localparam noc_chdr_pkg::t_set_addr ADDR_COEF  = `SR_FIR_BASE + `SR_FIR_COEF;
  localparam noc_chdr_pkg::t_set_addr ADDR_CLEAR = `SR_FIR_BASE + `SR_FIR_CLEAR;

  logic                 half_sel;
  logic                 pre_fire;
  fir_dsp_pkg::t_sample pack_hi;
  logic                 pack_full;
  logic                 post_fire;
  logic                 hit_coef;
  logic                 hit_clear;

  //////////////////////////////////////////////////////////////////////
  // Config register
  //////////////////////////////////////////////////////////////////////

  assign hit_coef  = i_set_stb & (i_set_addr == ADDR_COEF);
  assign hit_clear = i_set_stb & (i_set_addr == ADDR_CLEAR);

  // Filter takes every beat, so one cycle is enough
  always_ff @(posedge bus_clk or negedge i_arst_n) begin
    if (!i_arst_n) o_cfg_valid <= 1'b0;
    else           o_cfg_valid <= hit_coef | hit_clear;
  end

  always_ff @(posedge bus_clk) begin
    if (i_set_stb) begin
      o_cfg_coef  <= i_set_data[`FIR_COEF_W-1:0];
      o_cfg_clear <= hit_clear;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Line to samples
  //////////////////////////////////////////////////////////////////////

  // High half first, line released after low half
  assign o_pre_tdata  = half_sel ? i_tdata[`NOC_SAMPLE_W-1:0]
                                 : i_tdata[`NOC_LINE_W-1:`NOC_SAMPLE_W];
  assign o_pre_tlast  = i_tlast & half_sel;
  assign o_pre_tvalid = i_tvalid;
  assign o_tready     = i_pre_tready & half_sel;
  assign pre_fire     = i_tvalid & i_pre_tready;

  always_ff @(posedge bus_clk or negedge i_arst_n) begin
    if (!i_arst_n)     half_sel <= 1'b0;
    else if (pre_fire) half_sel <= ~half_sel;
  end

  //////////////////////////////////////////////////////////////////////
  // Samples to line
  //////////////////////////////////////////////////////////////////////

  // First result parks here, second one completes the line
  assign o_tdata       = {pack_hi, i_post_tdata};
  assign o_tlast       = i_post_tlast;
  assign o_tvalid      = pack_full & i_post_tvalid;
  assign o_post_tready = ~pack_full | i_tready;
  assign post_fire     = i_post_tvalid & o_post_tready;

  always_ff @(posedge bus_clk or negedge i_arst_n) begin
    if (!i_arst_n)      pack_full <= 1'b0;
    else if (post_fire) pack_full <= ~pack_full;
  end

  always_ff @(posedge bus_clk) begin
    if (post_fire && !pack_full) pack_hi <= i_post_tdata;
  end

endmodule

/* fir_core.sv */
`timescale 1ns/1ps
`include "noc_block_macros.svh"

module fir_core (
  input  logic                 bus_clk,
  input  logic                 i_arst_n,
  // Config stream, always accepted
  input  fir_dsp_pkg::t_coef   i_cfg_coef,
  input  logic                 i_cfg_clear,
  input  logic                 i_cfg_valid,
  // Sample input
  input  fir_dsp_pkg::t_sample i_tdata,
  input  logic                 i_tlast,
  input  logic                 i_tvalid,
  output logic                 o_tready,
  // Filtered output
  output fir_dsp_pkg::t_sample o_tdata,
  output logic                 o_tlast,
  output logic                 o_tvalid,
  input  logic                 i_tready
);

  localparam int NTAPS  = `FIR_NUM_TAPS;
  localparam int PROD_W = 2 * `FIR_COEF_W;

  fir_dsp_pkg::t_sample_beat beat_in;
  fir_dsp_pkg::t_sample_beat beat;
  logic                      beat_valid;
  logic                      adv;
  logic                      take;
  fir_dsp_pkg::t_coef        coef [NTAPS];
  // Past samples, newest at index 0
  fir_dsp_pkg::t_sample      hist [NTAPS-1];
  fir_dsp_pkg::t_sample      win  [NTAPS];
  logic signed [PROD_W-1:0]  prod_i [NTAPS];
  logic signed [PROD_W-1:0]  prod_q [NTAPS];
  logic                      s1_valid;
  logic                      s1_last;
  fir_dsp_pkg::t_acc         sum_i;
  fir_dsp_pkg::t_acc         sum_q;

  // Scale back to Q1.15 and clip to 16 bits
  function automatic logic signed [15:0] sat16(input fir_dsp_pkg::t_acc a);
    fir_dsp_pkg::t_acc s;
    s = a >>> 15;
    if (s > 36'sd32767)       return 16'sh7fff;
    else if (s < -36'sd32768) return 16'sh8000;
    else                      return s[15:0];
  endfunction

  assign beat_in = '{data: i_tdata, last: i_tlast};

  axis_skid_buffer #(.t_payload(fir_dsp_pkg::t_sample_beat)) u_in_skid (
    .bus_clk (bus_clk),
    .i_arst_n(i_arst_n),
    .i_data  (beat_in),
    .i_valid (i_tvalid),
    .o_ready (o_tready),
    .o_data  (beat),
    .o_valid (beat_valid),
    .i_ready (adv)
  );

  // Whole pipe moves together
  assign adv  = ~o_tvalid | i_tready;
  assign take = beat_valid & adv;

  //////////////////////////////////////////////////////////////////////
  // Coefficients and history
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      coef <= '{default: '0};
    end else if (i_cfg_valid) begin
      if (i_cfg_clear) begin
        coef <= '{default: '0};
      end else begin
        // Newest write enters tap 0
        coef[0] <= i_cfg_coef;
        for (int k = 1; k < NTAPS; k++) coef[k] <= coef[k-1];
      end
    end
  end

  // Current sample plus history
  always_comb begin
    win[0] = beat.data;
    for (int k = 1; k < NTAPS; k++) win[k] = hist[k-1];
  end

  // Cleared after last so packets stay independent
  always_ff @(posedge bus_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      hist <= '{default: '0};
    end else if (take) begin
      if (beat.last) hist <= '{default: '0};
      else for (int k = 0; k < NTAPS-1; k++) hist[k] <= win[k];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage 1, products
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk or negedge i_arst_n) begin
    if (!i_arst_n)  s1_valid <= 1'b0;
    else if (adv)   s1_valid <= beat_valid;
  end

  always_ff @(posedge bus_clk) begin
    if (take) begin
      s1_last <= beat.last;
      for (int k = 0; k < NTAPS; k++) begin
        prod_i[k] <= coef[k] * win[k].i;
        prod_q[k] <= coef[k] * win[k].q;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage 2, sum, scale, saturate
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    sum_i = '0;
    sum_q = '0;
    for (int k = 0; k < NTAPS; k++) begin
      sum_i = sum_i + prod_i[k];
      sum_q = sum_q + prod_q[k];
    end
  end

  always_ff @(posedge bus_clk or negedge i_arst_n) begin
    if (!i_arst_n) o_tvalid <= 1'b0;
    else if (adv)  o_tvalid <= s1_valid;
  end

  always_ff @(posedge bus_clk) begin
    if (adv && s1_valid) begin
      o_tdata.i <= sat16(sum_i);
      o_tdata.q <= sat16(sum_q);
      o_tlast   <= s1_last;
    end
  end

endmodule

/* noc_block_fir_filter.sv */
`timescale 1ns/1ps
`include "noc_block_macros.svh"

module noc_block_fir_filter (
  input  logic                   bus_clk,
  input  logic                   i_arst_n,
  // Packets in
  input  logic [`NOC_LINE_W-1:0] i_tdata,
  input  logic                   i_tlast,
  input  logic                   i_tvalid,
  output logic                   o_tready,
  // Packets out
  output logic [`NOC_LINE_W-1:0] o_tdata,
  output logic                   o_tlast,
  output logic                   o_tvalid,
  input  logic                   i_tready
);

  //////////////////////////////////////////////////////////////////////
  // Shell
  //////////////////////////////////////////////////////////////////////

  // Settings strobe
  logic                    set_stb;
  noc_chdr_pkg::t_set_addr set_addr;
  logic [31:0]             set_data;

  // Payload lines, both directions
  logic [`NOC_LINE_W-1:0]  sink_tdata;
  logic                    sink_tlast;
  logic                    sink_tvalid;
  logic                    sink_tready;
  logic [`NOC_LINE_W-1:0]  src_tdata;
  logic                    src_tlast;
  logic                    src_tvalid;
  logic                    src_tready;

  noc_shell_lite u_shell (
    .bus_clk      (bus_clk),
    .i_arst_n     (i_arst_n),
    .i_tdata      (i_tdata),
    .i_tlast      (i_tlast),
    .i_tvalid     (i_tvalid),
    .o_tready     (o_tready),
    .o_tdata      (o_tdata),
    .o_tlast      (o_tlast),
    .o_tvalid     (o_tvalid),
    .i_tready     (i_tready),
    .o_set_stb    (set_stb),
    .o_set_addr   (set_addr),
    .o_set_data   (set_data),
    .o_sink_tdata (sink_tdata),
    .o_sink_tlast (sink_tlast),
    .o_sink_tvalid(sink_tvalid),
    .i_sink_tready(sink_tready),
    .i_src_tdata  (src_tdata),
    .i_src_tlast  (src_tlast),
    .i_src_tvalid (src_tvalid),
    .o_src_tready (src_tready)
  );

  //////////////////////////////////////////////////////////////////////
  // Wrapper and filter
  //////////////////////////////////////////////////////////////////////

  // Sample streams around the filter
  fir_dsp_pkg::t_sample pre_tdata;
  logic                 pre_tlast;
  logic                 pre_tvalid;
  logic                 pre_tready;
  fir_dsp_pkg::t_sample post_tdata;
  logic                 post_tlast;
  logic                 post_tvalid;
  logic                 post_tready;

  // Coefficient config
  fir_dsp_pkg::t_coef   cfg_coef;
  logic                 cfg_clear;
  logic                 cfg_valid;

  simple_axi_wrapper u_wrapper (
    .bus_clk      (bus_clk),
    .i_arst_n     (i_arst_n),
    .i_set_stb    (set_stb),
    .i_set_addr   (set_addr),
    .i_set_data   (set_data),
    .i_tdata      (sink_tdata),
    .i_tlast      (sink_tlast),
    .i_tvalid     (sink_tvalid),
    .o_tready     (sink_tready),
    .o_tdata      (src_tdata),
    .o_tlast      (src_tlast),
    .o_tvalid     (src_tvalid),
    .i_tready     (src_tready),
    .o_pre_tdata  (pre_tdata),
    .o_pre_tlast  (pre_tlast),
    .o_pre_tvalid (pre_tvalid),
    .i_pre_tready (pre_tready),
    .i_post_tdata (post_tdata),
    .i_post_tlast (post_tlast),
    .i_post_tvalid(post_tvalid),
    .o_post_tready(post_tready),
    .o_cfg_coef   (cfg_coef),
    .o_cfg_clear  (cfg_clear),
    .o_cfg_valid  (cfg_valid)
  );

  fir_core u_fir (
    .bus_clk    (bus_clk),
    .i_arst_n   (i_arst_n),
    .i_cfg_coef (cfg_coef),
    .i_cfg_clear(cfg_clear),
    .i_cfg_valid(cfg_valid),
    .i_tdata    (pre_tdata),
    .i_tlast    (pre_tlast),
    .i_tvalid   (pre_tvalid),
    .o_tready   (pre_tready),
    .o_tdata    (post_tdata),
    .o_tlast    (post_tlast),
    .o_tvalid   (post_tvalid),
    .i_tready   (post_tready)
  );

endmodule

/* noc_block_asserts.sv */
`timescale 1ns/1ps
`include "noc_block_macros.svh"

module noc_block_asserts (
  input logic                   bus_clk,
  input logic                   i_arst_n,
  // Output stream of the block
  input logic [`NOC_LINE_W-1:0] i_out_tdata,
  input logic                   i_out_tlast,
  input logic                   i_out_tvalid,
  input logic                   i_out_tready
);

  // Count of failed checks
  int unsigned fail_cnt = 0;

  //////////////////////////////////////////////////////////////////////
  // Output stream protocol
  //////////////////////////////////////////////////////////////////////

  // Stalled beat keeps its contents
  property p_hold_data;
    @(posedge bus_clk) disable iff (!i_arst_n)
      (i_out_tvalid && !i_out_tready) |=> ($stable(i_out_tdata) && $stable(i_out_tlast));
  endproperty

  // Valid stays up until taken
  property p_hold_valid;
    @(posedge bus_clk) disable iff (!i_arst_n)
      (i_out_tvalid && !i_out_tready) |=> i_out_tvalid;
  endproperty

  // Nothing offered during reset
  property p_quiet_in_reset;
    @(posedge bus_clk) !i_arst_n |=> !i_out_tvalid;
  endproperty

  a_hold_data: assert property (p_hold_data) else begin
    $error("o_tdata or o_tlast changed while the beat was stalled");
    fail_cnt++;
  end

  a_hold_valid: assert property (p_hold_valid) else begin
    $error("o_tvalid dropped before the beat was taken");
    fail_cnt++;
  end

  a_quiet_in_reset: assert property (p_quiet_in_reset) else begin
    $error("o_tvalid went high while reset was active");
    fail_cnt++;
  end

endmodule

/* tb_noc_block_fir_filter.sv */
`timescale 1ns/1ps
`include "noc_block_macros.svh"

module tb_noc_block_fir_filter;

  localparam int NTAPS = `FIR_NUM_TAPS;
  // In plus out lines summed over the six tests
  localparam int TOTAL_BEATS = 6 + 19 + 77 + 68 + 29 + 12;
  localparam int WD_CYCLES   = TOTAL_BEATS * 20;
  localparam logic [7:0] ADDR_COEF  = `SR_FIR_BASE + `SR_FIR_COEF;
  localparam logic [7:0] ADDR_CLEAR = `SR_FIR_BASE + `SR_FIR_CLEAR;

  logic                   bus_clk;
  logic                   i_arst_n;
  logic [`NOC_LINE_W-1:0] i_tdata;
  logic                   i_tlast;
  logic                   i_tvalid;
  logic                   o_tready;
  logic [`NOC_LINE_W-1:0] o_tdata;
  logic                   o_tlast;
  logic                   o_tvalid;
  logic                   i_tready;

  logic [31:0]            lfsr;
  // Lines still to drive and lines still expected
  logic [`NOC_LINE_W-1:0] in_data  [$];
  logic                   in_last  [$];
  logic [`NOC_LINE_W-1:0] exp_data [$];
  logic                   exp_last [$];
  // Samples of the packet being modeled
  fir_dsp_pkg::t_sample   pkt_smp  [$];
  fir_dsp_pkg::t_coef     model_coef [NTAPS];
  fir_dsp_pkg::t_coef     coef_set   [NTAPS];
  string                  cur_test;
  int                     test_errs;
  int                     tests_passed;
  int                     tests_failed;
  int unsigned            proto_errs;

  noc_block_fir_filter i_dut (
    .bus_clk (bus_clk),
    .i_arst_n(i_arst_n),
    .i_tdata (i_tdata),
    .i_tlast (i_tlast),
    .i_tvalid(i_tvalid),
    .o_tready(o_tready),
    .o_tdata (o_tdata),
    .o_tlast (o_tlast),
    .o_tvalid(o_tvalid),
    .i_tready(i_tready)
  );

  // Protocol checks on the block output
  bind noc_block_fir_filter noc_block_asserts u_asserts (
    .bus_clk     (bus_clk),
    .i_arst_n    (i_arst_n),
    .i_out_tdata (o_tdata),
    .i_out_tlast (o_tlast),
    .i_out_tvalid(o_tvalid),
    .i_out_tready(i_tready)
  );

  initial begin
    bus_clk = 1'b0;
    forever #4 bus_clk = ~bus_clk;
  end

  initial begin
    repeat (WD_CYCLES) @(posedge bus_clk);
    $display("timeout: output beats still missing after %0d cycles", WD_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR on x^32+x^22+x^2+x+1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int b = 0; b < n; b++) begin
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) lfsr = lfsr ^ 32'h8020_0003;
      val = {val[30:0], lsb};
    end
    return val;
  endfunction

  // One lane of y[n] with history starting at zero for each packet
  function automatic logic [15:0] model_lane(input int n, input bit lane_i);
    longint acc;
    longint x;
    acc = 0;
    for (int k = 0; k < NTAPS; k++) begin
      if (n - k >= 0) begin
        if (lane_i) x = longint'(pkt_smp[n-k].i);
        else        x = longint'(pkt_smp[n-k].q);
        acc = acc + longint'(model_coef[k]) * x;
      end
    end
    acc = acc >>> 15;
    if (acc > 32767) return 16'h7fff;
    if (acc < -32768) return 16'h8000;
    return acc[15:0];
  endfunction

  // Queue a data packet and its expected reply
  task automatic add_data_packet(input logic [15:0] sid, input int nlines, input bit impulse);
    noc_chdr_pkg::t_chdr_hdr hdr;
    fir_dsp_pkg::t_sample    s;
    hdr          = '0;
    hdr.pkt_type = noc_chdr_pkg::PKT_DATA;
    hdr.sid      = sid;
    hdr.len      = 16'(nlines);
    in_data.push_back(hdr);
    in_last.push_back(1'b0);
    exp_data.push_back(hdr);
    exp_last.push_back(1'b0);
    pkt_smp.delete();
    for (int n = 0; n < 2 * nlines; n++) begin
      if (impulse) s = (n == 0) ? 32'h7fff_7fff : 32'h0;
      else         s = rand_bits(32);
      pkt_smp.push_back(s);
    end
    for (int m = 0; m < nlines; m++) begin
      // First sample in the high half
      in_data.push_back({pkt_smp[2*m], pkt_smp[2*m+1]});
      in_last.push_back(m == nlines - 1);
      exp_data.push_back({model_lane(2*m, 1'b1), model_lane(2*m, 1'b0),
                          model_lane(2*m+1, 1'b1), model_lane(2*m+1, 1'b0)});
      exp_last.push_back(m == nlines - 1);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stream drivers entered and left on a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic drive_input();
    while (in_data.size() > 0) begin
      i_tdata  = in_data.pop_front();
      i_tlast  = in_last.pop_front();
      i_tvalid = 1'b1;
      // Ready is a flop and holds until the next rising edge
      while (!o_tready) @(negedge bus_clk);
      @(negedge bus_clk);
    end
    i_tvalid = 1'b0;
  endtask

  task automatic collect_output(input bit rand_ready);
    logic [`NOC_LINE_W-1:0] want_d;
    logic                   want_l;
    int                     line;
    line = 0;
    while (exp_data.size() > 0) begin
      i_tready = rand_ready ? (rand_bits(1) != 0) : 1'b1;
      if (o_tvalid && i_tready) begin
        want_d = exp_data.pop_front();
        want_l = exp_last.pop_front();
        assert (o_tdata === want_d) else begin
          $display("error: test %s, line %0d data, expected %h, actual %h",
                   cur_test, line, want_d, o_tdata);
          test_errs++;
        end
        assert (o_tlast === want_l) else begin
          $display("error: test %s, line %0d last, expected %b, actual %b",
                   cur_test, line, want_l, o_tlast);
          test_errs++;
        end
        line++;
      end
      @(negedge bus_clk);
    end
    i_tready = 1'b1;
  endtask

  task automatic run_traffic(input bit rand_ready);
    fork
      drive_input();
      collect_output(rand_ready);
    join
  endtask

  // Command packet of NTAPS coefficient writes
  task automatic load_coefs();
    noc_chdr_pkg::t_chdr_hdr hdr;
    hdr          = '0;
    hdr.pkt_type = noc_chdr_pkg::PKT_CMD;
    hdr.sid      = 16'h00f0;
    hdr.len      = 16'(NTAPS);
    in_data.push_back(hdr);
    in_last.push_back(1'b0);
    for (int w = 0; w < NTAPS; w++) begin
      in_data.push_back({24'h0, ADDR_COEF, 16'h0, coef_set[w]});
      in_last.push_back(w == NTAPS - 1);
      // Each write moves the chain one tap on
      for (int k = NTAPS - 1; k > 0; k--) model_coef[k] = model_coef[k-1];
      model_coef[0] = coef_set[w];
    end
    drive_input();
    repeat (4) @(negedge bus_clk);
  endtask

  task automatic clear_coefs();
    noc_chdr_pkg::t_chdr_hdr hdr;
    hdr          = '0;
    hdr.pkt_type = noc_chdr_pkg::PKT_CMD;
    hdr.sid      = 16'h00f1;
    hdr.len      = 16'd1;
    in_data.push_back(hdr);
    in_last.push_back(1'b0);
    in_data.push_back({24'h0, ADDR_CLEAR, 32'h1});
    in_last.push_back(1'b1);
    model_coef = '{default: '0};
    drive_input();
    repeat (4) @(negedge bus_clk);
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      tests_passed++;
      $display("test %s: passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", cur_test, test_errs);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    lfsr         = 32'hcfd1;
    i_arst_n     = 1'b0;
    i_tdata      = '0;
    i_tlast      = 1'b0;
    i_tvalid     = 1'b0;
    i_tready     = 1'b1;
    model_coef   = '{default: '0};
    tests_passed = 0;
    tests_failed = 0;
    repeat (5) @(negedge bus_clk);
    i_arst_n = 1'b1;

    // Quiet output and then zeros from zero taps
    start_test("reset");
    repeat (20) begin
      @(negedge bus_clk);
      assert (!o_tvalid) else begin
        $display("error: test %s, o_tvalid expected 0, actual %b", cur_test, o_tvalid);
        test_errs++;
      end
    end
    add_data_packet(16'h0011, 2, 1'b0);
    run_traffic(1'b0);
    end_test();

    // Impulse replays the taps
    start_test("impulse");
    coef_set = '{16'sh4000, 16'sh2000, 16'sh1000, 16'sh0800,
                 16'shc000, 16'sh0400, 16'sh0200, 16'sh0100};
    load_coefs();
    add_data_packet(16'h0022, 4, 1'b1);
    run_traffic(1'b0);
    end_test();

    // Full scale random taps push the sum into saturation
    start_test("random_saturation");
    for (int w = 0; w < NTAPS; w++) coef_set[w] = 16'(rand_bits(16));
    load_coefs();
    add_data_packet(16'h0033, 16, 1'b0);
    add_data_packet(16'h0034, 16, 1'b0);
    run_traffic(1'b0);
    end_test();

    start_test("back_pressure");
    add_data_packet(16'h0044, 16, 1'b0);
    add_data_packet(16'h0045, 16, 1'b0);
    run_traffic(1'b1);
    end_test();

    // Back to back packets must not share history
    start_test("framing");
    coef_set = '{16'sh0100, 16'sh0200, 16'sh0400, 16'sh0800,
                 16'sh1000, 16'sh2000, 16'sh4000, 16'sh0c00};
    load_coefs();
    add_data_packet(16'h0055, 4, 1'b0);
    add_data_packet(16'h0056, 4, 1'b0);
    run_traffic(1'b0);
    end_test();

    start_test("clear");
    clear_coefs();
    add_data_packet(16'h0066, 4, 1'b0);
    run_traffic(1'b0);
    end_test();

    proto_errs = i_dut.u_asserts.fail_cnt;
    $display("tests: %0d passed, %0d failed, %0d protocol assertion failures",
             tests_passed, tests_failed, proto_errs);
    if (tests_failed == 0 && proto_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+.
noc_chdr_pkg.sv
fir_dsp_pkg.sv
axis_skid_buffer.sv
noc_shell_lite.sv
simple_axi_wrapper.sv
fir_core.sv
noc_block_fir_filter.sv
noc_block_asserts.sv
tb_noc_block_fir_filter.sv
